/* rtl/ooo_params.svh */
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// Datapath
`define XLEN 32

// Architectural and physical register files
`define NUM_ARCH_REGS 32
`define ARCH_BITS 5
`define NUM_PHYS_REGS 48
`define PHYS_BITS 6

// Out-of-order window
`define ROB_DEPTH 16
`define ROB_BITS 4
`define RS_DEPTH 8

`endif

/* rtl/ooo_pkg.sv */
`include "ooo_params.svh"

package ooo_pkg;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    // Decoder output, architectural indices only
    typedef struct packed {
        logic [`ARCH_BITS-1:0] rs1;
        logic [`ARCH_BITS-1:0] rs2;
        logic [`ARCH_BITS-1:0] rd;
        alu_op_e               alu_op;
        logic                  alu_src;    // Immediate replaces source 2
        logic                  reg_write;
        logic [`XLEN-1:0]      imm;
    } decoded_t;

    typedef struct packed {
        logic [`PHYS_BITS-1:0] prs1;
        logic [`PHYS_BITS-1:0] prs2;
        logic [`PHYS_BITS-1:0] prd;
        logic [`PHYS_BITS-1:0] prd_old;    // Freed when this one commits
        logic [`ARCH_BITS-1:0] ard;
        logic                  rs1_ready;
        logic                  rs2_ready;
        alu_op_e               alu_op;
        logic                  alu_src;
        logic                  reg_write;
        logic [`XLEN-1:0]      imm;
    } renamed_t;

    typedef struct packed {
        logic [`PHYS_BITS-1:0] prs1;
        logic [`PHYS_BITS-1:0] prs2;
        logic [`PHYS_BITS-1:0] prd;
        logic                  rs1_ready;
        logic                  rs2_ready;
        alu_op_e               alu_op;
        logic                  alu_src;
        logic                  reg_write;
        logic [`XLEN-1:0]      imm;
        logic [`ROB_BITS-1:0]  rob_tag;
    } rs_entry_t;

    // Result broadcast from the ALU
    typedef struct packed {
        logic                  valid;
        logic [`PHYS_BITS-1:0] prd;
        logic                  reg_write;
        logic [`ROB_BITS-1:0]  rob_tag;
        logic [`XLEN-1:0]      data;
    } wb_t;

    typedef struct packed {
        logic                  valid;
        logic [`ARCH_BITS-1:0] ard;
        logic                  reg_write;
        logic [`XLEN-1:0]      data;
        logic [`PHYS_BITS-1:0] prd_old;
    } commit_t;

endpackage

/* rtl/skid_buffer.sv */
module skid_buffer #(
    parameter type T = logic [31:0]
) (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);

    logic spill_valid;
    T     spill_data;

    assign in_ready = !spill_valid;    // Straight from a flop

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid   <= 1'b0;
            spill_valid <= 1'b0;
        end else if (out_ready || !out_valid) begin
            // Output slot drains, spill goes first
            out_valid   <= spill_valid || in_valid;
            spill_valid <= 1'b0;
        end else if (in_valid && !spill_valid) begin
            spill_valid <= 1'b1;    // Catch the beat in flight
        end
    end

    always_ff @(posedge clk) begin
        if (out_ready || !out_valid) begin
            out_data <= spill_valid ? spill_data : in_data;
        end else if (in_valid && !spill_valid) begin
            spill_data <= in_data;
        end
    end

endmodule

/* rtl/decoder.sv */
`include "ooo_params.svh"

module decoder import ooo_pkg::*; (
    input  logic [`XLEN-1:0] instr,
    output decoded_t         decoded
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        legal           = 1'b1;
        decoded.rs1     = instr[19:15];
        decoded.rs2     = instr[24:20];
        decoded.rd      = instr[11:7];
        decoded.alu_op  = ALU_ADD;
        decoded.alu_src = 1'b0;
        decoded.imm     = {{(`XLEN-12){instr[31]}}, instr[31:20]};

        if (opcode == OPC_OP && funct7 == 7'b0000000) begin
            case (funct3)
                3'b000:  decoded.alu_op = ALU_ADD;
                3'b010:  decoded.alu_op = ALU_SLT;
                3'b100:  decoded.alu_op = ALU_XOR;
                3'b110:  decoded.alu_op = ALU_OR;
                3'b111:  decoded.alu_op = ALU_AND;
                default: legal = 1'b0;
            endcase
        end else if (opcode == OPC_OP && funct7 == 7'b0100000 && funct3 == 3'b000) begin
            decoded.alu_op = ALU_SUB;
        end else if (opcode == OPC_OP_IMM && funct3 == 3'b000) begin
            decoded.alu_src = 1'b1;    // ADDI
            decoded.rs2     = '0;
        end else begin
            legal = 1'b0;
        end

        // Anything else turns into a harmless ADD of x0
        if (!legal) begin
            decoded.rs1     = '0;
            decoded.rs2     = '0;
            decoded.alu_op  = ALU_ADD;
            decoded.alu_src = 1'b0;
        end
        decoded.reg_write = legal && (decoded.rd != '0);
    end

endmodule

/* rtl/rename.sv */
`include "ooo_params.svh"

module rename import ooo_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  decoded_t in_data,
    input  logic     rob_space,
    input  logic     rs_space,
    output logic     dispatch_valid,
    output renamed_t dispatch_data,
    input  wb_t      wb,
    input  commit_t  commit
);

    localparam int FL_DEPTH = `NUM_PHYS_REGS - `NUM_ARCH_REGS;
    localparam int FL_BITS  = $clog2(FL_DEPTH);

    logic [`PHYS_BITS-1:0]     map_table [`NUM_ARCH_REGS];
    logic [`PHYS_BITS-1:0]     free_list [FL_DEPTH];
    logic [FL_BITS-1:0]        fl_head;
    logic [FL_BITS-1:0]        fl_tail;
    logic [FL_BITS:0]          fl_count;
    logic [`NUM_PHYS_REGS-1:0] busy;
    logic [`PHYS_BITS-1:0]     prs1;
    logic [`PHYS_BITS-1:0]     prs2;
    logic                      alloc;
    logic                      release_old;
    logic                      wb_wake;

    assign prs1        = map_table[in_data.rs1];
    assign prs2        = map_table[in_data.rs2];
    assign wb_wake     = wb.valid && wb.reg_write;
    assign release_old = commit.valid && commit.reg_write;

    // Stall on an empty free list, a full ROB or a full RS
    assign in_ready = (fl_count != '0 || !in_data.reg_write) && rob_space && rs_space;
    assign dispatch_valid = in_valid && in_ready;
    assign alloc          = dispatch_valid && in_data.reg_write;

    always_comb begin
        dispatch_data.prs1      = prs1;
        dispatch_data.prs2      = prs2;
        dispatch_data.prd       = in_data.reg_write ? free_list[fl_head] : '0;
        dispatch_data.prd_old   = in_data.reg_write ? map_table[in_data.rd] : '0;
        dispatch_data.ard       = in_data.rd;
        // Result broadcast this cycle counts as ready
        dispatch_data.rs1_ready = !busy[prs1] || (wb_wake && wb.prd == prs1);
        dispatch_data.rs2_ready = !busy[prs2] || (wb_wake && wb.prd == prs2);
        dispatch_data.alu_op    = in_data.alu_op;
        dispatch_data.alu_src   = in_data.alu_src;
        dispatch_data.reg_write = in_data.reg_write;
        dispatch_data.imm       = in_data.imm;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
                map_table[i] <= `PHYS_BITS'(i);    // Identity map
            end
            for (int i = 0; i < FL_DEPTH; i++) begin
                free_list[i] <= `PHYS_BITS'(`NUM_ARCH_REGS + i);
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= (FL_BITS+1)'(FL_DEPTH);
            busy     <= '0;
        end else begin
            if (wb_wake) begin
                busy[wb.prd] <= 1'b0;
            end
            if (alloc) begin
                map_table[in_data.rd]   <= free_list[fl_head];
                busy[free_list[fl_head]] <= 1'b1;
                fl_head                 <= fl_head + 1'b1;
            end
            if (release_old) begin
                free_list[fl_tail] <= commit.prd_old;
                fl_tail            <= fl_tail + 1'b1;
            end
            fl_count <= fl_count + (FL_BITS+1)'(release_old) - (FL_BITS+1)'(alloc);
        end
    end

endmodule

/* rtl/rob.sv */
`include "ooo_params.svh"

module rob import ooo_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dispatch_valid,
    input  renamed_t             dispatch_data,
    output logic [`ROB_BITS-1:0] alloc_tag,
    output logic                 space,
    input  wb_t                  wb,
    output commit_t              commit
);

    logic [`ARCH_BITS-1:0] ard_q     [`ROB_DEPTH];
    logic [`PHYS_BITS-1:0] prd_old_q [`ROB_DEPTH];
    logic [`XLEN-1:0]      data_q    [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] reg_write_q;
    logic [`ROB_DEPTH-1:0] done;
    logic [`ROB_BITS-1:0]  head;
    logic [`ROB_BITS-1:0]  tail;
    logic [`ROB_BITS:0]    count;
    logic                  wb_head;
    logic                  retire;

    assign alloc_tag = tail;
    assign space     = count != (`ROB_BITS+1)'(`ROB_DEPTH);
    assign wb_head   = wb.valid && wb.rob_tag == head;
    assign retire    = count != '0 && (done[head] || wb_head);    // Head done or finishing now

    // Entry storage
    always_ff @(posedge clk) begin
        if (dispatch_valid) begin
            ard_q[tail]       <= dispatch_data.ard;
            prd_old_q[tail]   <= dispatch_data.prd_old;
            reg_write_q[tail] <= dispatch_data.reg_write;
        end
        if (wb.valid) begin
            data_q[wb.rob_tag] <= wb.data;
        end
    end

    always_ff @(posedge clk) begin
        commit.ard       <= ard_q[head];
        commit.reg_write <= reg_write_q[head];
        commit.prd_old   <= prd_old_q[head];
        commit.data      <= wb_head ? wb.data : data_q[head];
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            commit.valid <= 1'b0;
        end else begin
            commit.valid <= retire;
            if (dispatch_valid) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (wb.valid) begin
                done[wb.rob_tag] <= 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            count <= count + (`ROB_BITS+1)'(dispatch_valid) - (`ROB_BITS+1)'(retire);
        end
    end

endmodule

/* rtl/reservation_station.sv */
`include "ooo_params.svh"

module reservation_station import ooo_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dispatch_valid,
    input  renamed_t             dispatch_data,
    input  logic [`ROB_BITS-1:0] alloc_tag,
    output logic                 space,
    input  wb_t                  wb,
    output logic                 issue_valid,
    output rs_entry_t            issue_entry
);

    localparam int RS_BITS = $clog2(`RS_DEPTH);

    rs_entry_t            slot [`RS_DEPTH];
    logic [RS_BITS-1:0]   age  [`RS_DEPTH];    // 0 is the oldest
    logic [`RS_DEPTH-1:0] valid;
    logic [`RS_DEPTH-1:0] ready;
    logic [RS_BITS-1:0]   issue_idx;
    logic [RS_BITS-1:0]   free_idx;
    logic [RS_BITS:0]     occupancy;
    logic [RS_BITS-1:0]   new_age;
    logic                 wb_wake;
    rs_entry_t            new_entry;

    assign wb_wake = wb.valid && wb.reg_write;

    // ==================================================
    // Oldest-ready select
    // ==================================================
    always_comb begin
        issue_valid = 1'b0;
        issue_idx   = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            ready[i] = valid[i] && slot[i].rs1_ready && (slot[i].rs2_ready || slot[i].alu_src);
            if (ready[i] && (!issue_valid || age[i] < age[issue_idx])) begin
                issue_valid = 1'b1;
                issue_idx   = RS_BITS'(i);
            end
        end
    end

    assign issue_entry = slot[issue_idx];

    // Lowest free slot and current fill level
    always_comb begin
        free_idx  = '0;
        space     = 1'b0;
        occupancy = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_idx = RS_BITS'(i);
                space    = 1'b1;
            end
            occupancy = occupancy + (RS_BITS+1)'(valid[i]);
        end
    end

    assign new_age = RS_BITS'(occupancy - (RS_BITS+1)'(issue_valid));

    always_comb begin
        new_entry.prs1      = dispatch_data.prs1;
        new_entry.prs2      = dispatch_data.prs2;
        new_entry.prd       = dispatch_data.prd;
        new_entry.rs1_ready = dispatch_data.rs1_ready;
        new_entry.rs2_ready = dispatch_data.rs2_ready;
        new_entry.alu_op    = dispatch_data.alu_op;
        new_entry.alu_src   = dispatch_data.alu_src;
        new_entry.reg_write = dispatch_data.reg_write;
        new_entry.imm       = dispatch_data.imm;
        new_entry.rob_tag   = alloc_tag;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else begin
            if (issue_valid) begin
                valid[issue_idx] <= 1'b0;
            end
            if (dispatch_valid) begin
                valid[free_idx] <= 1'b1;
            end
        end
    end

    // ==================================================
    // Wake-up and age compaction
    // ==================================================
    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (wb_wake && slot[i].prs1 == wb.prd) slot[i].rs1_ready <= 1'b1;
            if (wb_wake && slot[i].prs2 == wb.prd) slot[i].rs2_ready <= 1'b1;
            if (issue_valid && valid[i] && age[i] > age[issue_idx]) begin
                age[i] <= age[i] - 1'b1;    // Younger ones move up
            end
        end
        if (dispatch_valid) begin
            slot[free_idx] <= new_entry;
            age[free_idx]  <= new_age;
        end
    end

endmodule

/* rtl/exec_unit.sv */
`include "ooo_params.svh"

module exec_unit import ooo_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      issue_valid,
    input  rs_entry_t issue_entry,
    output wb_t       wb
);

    logic [`XLEN-1:0] prf [`NUM_PHYS_REGS];
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] result;

    assign op_a = prf[issue_entry.prs1];
    assign op_b = issue_entry.alu_src ? issue_entry.imm : prf[issue_entry.prs2];

    always_comb begin
        case (issue_entry.alu_op)
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            ALU_SLT: result = `XLEN'($signed(op_a) < $signed(op_b));
            default: result = op_a + op_b;
        endcase
    end

    // Architectural state starts at zero, p0 stays zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_PHYS_REGS; i++) begin
                prf[i] <= '0;
            end
        end else if (issue_valid && issue_entry.reg_write && issue_entry.prd != '0) begin
            prf[issue_entry.prd] <= result;
        end
    end

    always_ff @(posedge clk) begin
        wb.prd       <= issue_entry.prd;
        wb.reg_write <= issue_entry.reg_write;
        wb.rob_tag   <= issue_entry.rob_tag;
        wb.data      <= result;
        if (rst) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= issue_valid;    // Single-cycle ALU
        end
    end

endmodule

/* rtl/ooo_core.sv */
`include "ooo_params.svh"

module ooo_core import ooo_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [`XLEN-1:0] in_instr,
    output commit_t          commit
);

    logic                 instr_valid;
    logic                 instr_ready;
    logic [`XLEN-1:0]     instr_word;
    decoded_t             decoded;
    logic                 ren_valid;
    logic                 ren_ready;
    decoded_t             ren_data;
    logic                 rob_space;
    logic                 rs_space;
    logic                 dispatch_valid;
    renamed_t             dispatch_data;
    logic [`ROB_BITS-1:0] alloc_tag;
    logic                 issue_valid;
    rs_entry_t            issue_entry;
    wb_t                  wb;

    // ==================================================
    // In-order front end
    // ==================================================
    skid_buffer #(.T(logic [`XLEN-1:0])) fetch_skid_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_instr),
        .out_valid (instr_valid),
        .out_ready (instr_ready),
        .out_data  (instr_word)
    );

    decoder decoder_inst (
        .instr   (instr_word),
        .decoded (decoded)
    );

    // Decode is combinational, so valid and ready pass straight through
    skid_buffer #(.T(decoded_t)) decode_skid_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (instr_valid),
        .in_ready  (instr_ready),
        .in_data   (decoded),
        .out_valid (ren_valid),
        .out_ready (ren_ready),
        .out_data  (ren_data)
    );

    rename rename_inst (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (ren_valid),
        .in_ready       (ren_ready),
        .in_data        (ren_data),
        .rob_space      (rob_space),
        .rs_space       (rs_space),
        .dispatch_valid (dispatch_valid),
        .dispatch_data  (dispatch_data),
        .wb             (wb),
        .commit         (commit)
    );

    // ==================================================
    // Out-of-order back end
    // ==================================================
    rob rob_inst (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_data  (dispatch_data),
        .alloc_tag      (alloc_tag),
        .space          (rob_space),
        .wb             (wb),
        .commit         (commit)
    );

    reservation_station rs_inst (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_data  (dispatch_data),
        .alloc_tag      (alloc_tag),
        .space          (rs_space),
        .wb             (wb),
        .issue_valid    (issue_valid),
        .issue_entry    (issue_entry)
    );

    exec_unit exec_inst (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_entry (issue_entry),
        .wb          (wb)
    );

endmodule

/* sim/ooo_core_chk.sv */
`include "ooo_params.svh"

module ooo_core_chk (
    input logic               clk,
    input logic               rst,
    input logic               commit_valid,
    input logic [`ROB_BITS:0] rob_count,
    input logic               issue_valid,
    input logic               wb_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    // Nothing retires while reset is held
    commit_quiet_in_reset: assert property (@(posedge clk) rst |=> !commit_valid)
        else $error("commit valid while reset is held");

    rob_within_depth: assert property (@(posedge clk) disable iff (rst)
        rob_count <= (`ROB_BITS+1)'(`ROB_DEPTH))
        else $error("ROB count above its depth");

    // Single-cycle ALU
    wb_after_issue: assert property (@(posedge clk) disable iff (rst)
        issue_valid |=> wb_valid)
        else $error("no writeback one cycle after issue");

    wb_only_after_issue: assert property (@(posedge clk) disable iff (rst)
        !issue_valid |=> !wb_valid)
        else $error("writeback without an issue the cycle before");

endmodule

bind ooo_core ooo_core_chk ooo_core_chk_inst (
    .clk          (clk),
    .rst          (rst),
    .commit_valid (commit.valid),
    .rob_count    (rob_inst.count),
    .issue_valid  (issue_valid),
    .wb_valid     (wb.valid)
);

/* sim/ooo_core_tb.sv */
`include "ooo_params.svh"

module ooo_core_tb import ooo_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          NUM_INSTR      = 300;
    localparam int          TIMEOUT_CYCLES = NUM_INSTR * 20 + 100;
    localparam int          DRAIN_CYCLES   = 40;    // Window to catch stray commits
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

    logic             clk;
    logic             rst;
    logic             in_valid;
    logic             in_ready;
    logic [`XLEN-1:0] in_instr;
    commit_t          commit;

    logic [31:0]      lfsr_state;
    logic [`XLEN-1:0] arch_regs [`NUM_ARCH_REGS];
    logic [`XLEN-1:0] prog [NUM_INSTR];
    logic [`XLEN-1:0] expected [$];    // Words in program order
    logic [`PHYS_BITS-1:0] map_model [`NUM_ARCH_REGS];
    logic [`PHYS_BITS-1:0] free_model [$];    // Pops in allocation order
    int               error_count;
    int               commit_count;
    int               cycle_count;
    logic             input_seen;

    ooo_core ooo_core_inst (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_instr (in_instr),
        .commit   (commit)
    );

    always #2 clk = ~clk;

    // ==================================================
    // Stimulus generation
    // ==================================================
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        logic        bit_out;
        val = '0;
        for (int i = 0; i < n; i++) begin
            bit_out    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (bit_out) begin
                lfsr_state = lfsr_state ^ LFSR_TAPS;
            end
            val = {val[30:0], bit_out};
        end
        return val;
    endfunction

    function automatic logic [`XLEN-1:0] make_instr();
        logic [2:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [6:0]  funct7;
        logic [2:0]  funct3;
        kind   = 3'(lfsr_bits(3));
        rd     = 5'(lfsr_bits(3));    // x0 to x7 only
        rs1    = 5'(lfsr_bits(3));
        rs2    = 5'(lfsr_bits(3));
        imm    = 12'(lfsr_bits(12));
        funct7 = (kind == 3'd1) ? 7'b0100000 : 7'b0000000;
        case (kind)
            3'd0, 3'd1: funct3 = 3'b000;
            3'd2:       funct3 = 3'b111;
            3'd3:       funct3 = 3'b110;
            3'd4:       funct3 = 3'b100;
            3'd5:       funct3 = 3'b010;
            default:    funct3 = 3'b001;    // Unsupported SLL
        endcase
        if (kind == 3'd6) begin
            return {imm, rs1, 3'b000, rd, 7'b0010011};    // ADDI
        end
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    // ==================================================
    // Reference model and checks
    // ==================================================
    function automatic commit_t ref_commit(input logic [`XLEN-1:0] instr);
        commit_t          want;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] imm;
        logic             legal;
        a         = arch_regs[instr[19:15]];
        b         = arch_regs[instr[24:20]];
        imm       = {{20{instr[31]}}, instr[31:20]};
        legal     = 1'b1;
        want      = '0;
        want.valid = 1'b1;
        want.ard   = instr[11:7];
        if (instr[6:0] == 7'b0010011 && instr[14:12] == 3'b000) begin
            want.data = a + imm;
        end else if (instr[6:0] == 7'b0110011 && instr[31:25] == 7'b0100000) begin
            legal     = instr[14:12] == 3'b000;
            want.data = a - b;
        end else if (instr[6:0] == 7'b0110011 && instr[31:25] == 7'b0000000) begin
            case (instr[14:12])
                3'b000:  want.data = a + b;
                3'b010:  want.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b100:  want.data = a ^ b;
                3'b110:  want.data = a | b;
                3'b111:  want.data = a & b;
                default: legal = 1'b0;
            endcase
        end else begin
            legal = 1'b0;
        end
        want.reg_write = legal && want.ard != '0;    // x0 stays zero
        if (want.reg_write) begin
            arch_regs[want.ard] = want.data;
            // The replaced mapping goes back on the free list
            want.prd_old        = map_model[want.ard];
            map_model[want.ard] = free_model.pop_front();
            free_model.push_back(want.prd_old);
        end
        return want;
    endfunction

    task automatic check_commit(input commit_t got, input commit_t want);
        if (got.ard !== want.ard) begin
            error_count++;
            $display("ERR %0t: commit %0d ard %0d, expected %0d",
                     $time, commit_count, got.ard, want.ard);
        end
        if (got.reg_write !== want.reg_write) begin
            error_count++;
            $display("ERR %0t: commit %0d reg_write %0b, expected %0b",
                     $time, commit_count, got.reg_write, want.reg_write);
        end
        if (want.reg_write && got.data !== want.data) begin
            error_count++;
            $display("ERR %0t: commit %0d data %h, expected %h",
                     $time, commit_count, got.data, want.data);
        end
        if (want.reg_write && got.prd_old !== want.prd_old) begin
            error_count++;
            $display("ERR %0t: commit %0d prd_old %0d, expected %0d",
                     $time, commit_count, got.prd_old, want.prd_old);
        end
    endtask

    task automatic finish_run();
        $display("Commits %0d of %0d, errors %0d", commit_count, NUM_INSTR, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    // Fetch side holds a stalled beat until it is taken
    task automatic drive_program();
        int sent;
        sent = 0;
        while (sent < NUM_INSTR) begin
            @(posedge clk);
            if (in_valid && in_ready) begin
                sent++;
            end
            if (!in_valid || in_ready) begin
                if (sent < NUM_INSTR && lfsr_bits(2) != 32'd0) begin
                    in_valid <= 1'b1;
                    in_instr <= prog[sent];
                end else begin
                    in_valid <= 1'b0;    // Bubble or end of program
                end
            end
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_instr     = '0;
        lfsr_state   = 32'hc5f0;
        error_count  = 0;
        commit_count = 0;
        cycle_count  = 0;
        input_seen   = 1'b0;
        for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
            arch_regs[i] = '0;
            map_model[i] = `PHYS_BITS'(i);
        end
        for (int i = `NUM_ARCH_REGS; i < `NUM_PHYS_REGS; i++) begin
            free_model.push_back(`PHYS_BITS'(i));
        end
        for (int n = 0; n < NUM_INSTR; n++) begin
            prog[n] = make_instr();
            expected.push_back(prog[n]);
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        drive_program();
        wait (commit_count >= NUM_INSTR);
        repeat (DRAIN_CYCLES) @(posedge clk);
        if (commit_count != NUM_INSTR || expected.size() != 0) begin
            error_count++;
            $display("Saw %0d commits for %0d instructions", commit_count, NUM_INSTR);
        end
        finish_run();
    end

    // Commit monitor
    always @(posedge clk) begin
        commit_t want;
        cycle_count++;
        if (commit.valid) begin
            if (rst || !input_seen) begin
                error_count++;
                $display("ERR %0t: commit valid before any instruction was accepted", $time);
            end else if (expected.size() == 0) begin
                error_count++;
                $display("ERR %0t: extra commit after %0d instructions", $time, NUM_INSTR);
            end else begin
                want = ref_commit(expected.pop_front());
                check_commit(commit, want);
            end
            commit_count++;
        end
        if (!rst && in_valid && in_ready) begin
            input_seen = 1'b1;
        end
        if (cycle_count == TIMEOUT_CYCLES) begin
            error_count++;
            $display("Run timed out after %0d cycles with %0d of %0d commits",
                     cycle_count, commit_count, NUM_INSTR);
            finish_run();
        end
    end

endmodule

/* build.f */
+incdir+rtl
rtl/ooo_pkg.sv
rtl/skid_buffer.sv
rtl/decoder.sv
rtl/rename.sv
rtl/rob.sv
rtl/reservation_station.sv
rtl/exec_unit.sv
rtl/ooo_core.sv
sim/ooo_core_chk.sv
sim/ooo_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ooo_core_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
PASS_MSG  ?= TESTBENCH PASSED

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard rtl/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the simulation output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
